/* common/dma_pkg.sv */
package dma_pkg;

    // ==========================================================
    // Widths and sizes
    // ==========================================================
    localparam int DATA_WIDTH     = 32;
    localparam int ADDR_WIDTH     = 32;
    localparam int WORDS_WIDTH    = ADDR_WIDTH + 1;
    localparam int BYTES_PER_WORD = 4;

    // FIFO depth doubles as the longest AXI burst
    localparam int FIFO_DEPTH     = 8;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);

    // AXI bursts never cross this boundary
    localparam int PAGE_BYTES        = 4096;
    localparam int PAGE_OFFSET_WIDTH = $clog2(PAGE_BYTES);

    // ==========================================================
    // Destination address map
    // ==========================================================
    localparam int REGION_LSB        = 28;
    localparam int REGION_WIDTH      = 4;
    localparam int TILE_BANKS        = 4;
    localparam int TILE_BANK_BYTES   = 4096;
    localparam int TILE_OFFSET_WIDTH = $clog2(TILE_BANK_BYTES);
    localparam int TILE_BANK_WIDTH   = $clog2(TILE_BANKS);

    typedef logic [DATA_WIDTH-1:0]        data_t;
    typedef logic [ADDR_WIDTH-1:0]        addr_t;
    typedef logic [WORDS_WIDTH-1:0]       words_t;
    typedef logic [FIFO_PTR_WIDTH-1:0]    fifo_ptr_t;
    // Holds 0 up to FIFO_DEPTH inclusive
    typedef logic [FIFO_PTR_WIDTH:0]      fifo_count_t;
    typedef logic [7:0]                   axi_len_t;
    typedef logic [TILE_BANK_WIDTH-1:0]   tile_bank_t;
    typedef logic [TILE_OFFSET_WIDTH-1:0] tile_offset_t;

    // Top nibble of the destination; other codes are rejected
    typedef enum logic [REGION_WIDTH-1:0] {
        REGION_TILE   = 4'h1,
        REGION_CONFIG = 4'h2
    } dst_region_t;

    typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA, R_DONE} read_state_t;

    typedef enum logic [1:0] {W_IDLE, W_WAIT, W_WRITE} write_state_t;

    // Accepted transfer, word count already rounded up
    typedef struct packed {
        addr_t  src;
        addr_t  dst;
        words_t words;
    } dma_cmd_t;

    // AR channel payload, len is beats minus one
    typedef struct packed {
        addr_t    addr;
        axi_len_t len;
    } axi_ar_t;

    typedef struct packed {
        logic         we;
        tile_bank_t   bank;
        tile_offset_t offset;
        data_t        data;
    } tile_wr_t;

    typedef struct packed {
        logic  we;
        addr_t addr;
        data_t data;
    } cfg_wr_t;

endpackage

/* logic/cgra_dma_engine.sv */
`timescale 1ns/1ps

module cgra_dma_engine (
    input  logic              clk,
    input  logic              rst_n,

    // CSR side
    input  dma_pkg::addr_t    src_i,
    input  dma_pkg::addr_t    dst_i,
    input  dma_pkg::addr_t    size_i,
    input  logic              start_i,
    input  logic              abort_i,
    output logic              busy_o,
    output logic              done_o,
    output logic              irq_o,

    // AXI4 read master
    output dma_pkg::axi_ar_t  ar_o,
    output logic              arvalid_o,
    input  logic              arready_i,
    input  dma_pkg::data_t    rdata_i,
    input  logic              rlast_i,
    input  logic              rvalid_i,
    output logic              rready_o,

    // Local write ports
    output dma_pkg::tile_wr_t tile_wr_o,
    output dma_pkg::cfg_wr_t  cfg_wr_o
);

    dma_pkg::dma_cmd_t    cmd;
    logic                 cmd_start;
    logic                 rd_idle;
    logic                 wr_idle;

    // Producer to FIFO
    logic                 push;
    dma_pkg::data_t       push_data;
    dma_pkg::fifo_count_t fifo_free;
    logic                 fifo_full;

    // FIFO to consumer
    logic                 pop;
    dma_pkg::data_t       fifo_head;
    logic                 fifo_empty;

    // ==========================================================
    // Status, producer, FIFO and consumer
    // ==========================================================
    dma_status_ctrl u_status (
        .clk(clk), .rst_n(rst_n),
        .src_i(src_i), .dst_i(dst_i), .size_i(size_i),
        .start_i(start_i), .abort_i(abort_i),
        .rd_idle_i(rd_idle), .wr_idle_i(wr_idle), .fifo_empty_i(fifo_empty),
        .cmd_o(cmd), .cmd_start_o(cmd_start),
        .busy_o(busy_o), .done_o(done_o), .irq_o(irq_o)
    );

    dma_read_engine u_read (
        .clk(clk), .rst_n(rst_n), .abort_i(abort_i),
        .cmd_start_i(cmd_start), .cmd_i(cmd),
        .fifo_free_i(fifo_free), .fifo_full_i(fifo_full),
        .ar_o(ar_o), .arvalid_o(arvalid_o), .arready_i(arready_i),
        .rdata_i(rdata_i), .rlast_i(rlast_i), .rvalid_i(rvalid_i), .rready_o(rready_o),
        .push_o(push), .push_data_o(push_data), .idle_o(rd_idle)
    );

    // A new start flushes whatever an earlier transfer left behind
    dma_word_fifo u_fifo (
        .clk(clk), .rst_n(rst_n), .flush_i(cmd_start), .abort_i(abort_i),
        .push_i(push), .push_data_i(push_data), .pop_i(pop),
        .head_o(fifo_head), .free_o(fifo_free), .full_o(fifo_full), .empty_o(fifo_empty)
    );

    dma_local_writer u_writer (
        .clk(clk), .rst_n(rst_n), .abort_i(abort_i),
        .cmd_start_i(cmd_start), .cmd_i(cmd),
        .fifo_empty_i(fifo_empty), .fifo_head_i(fifo_head), .pop_o(pop),
        .tile_wr_o(tile_wr_o), .cfg_wr_o(cfg_wr_o), .idle_o(wr_idle)
    );

endmodule

/* logic/dma_status_ctrl.sv */
`timescale 1ns/1ps

module dma_status_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  dma_pkg::addr_t    src_i,
    input  dma_pkg::addr_t    dst_i,
    input  dma_pkg::addr_t    size_i,
    input  logic              start_i,
    input  logic              abort_i,
    input  logic              rd_idle_i,
    input  logic              wr_idle_i,
    input  logic              fifo_empty_i,
    output dma_pkg::dma_cmd_t cmd_o,
    output logic              cmd_start_o,
    output logic              busy_o,
    output logic              done_o,
    output logic              irq_o
);

    logic region_ok;
    logic accept;
    // Set one cycle after acceptance, once engines have left idle
    logic settled;
    logic done_q;

    assign region_ok = (dst_i[dma_pkg::REGION_LSB +: dma_pkg::REGION_WIDTH] == dma_pkg::REGION_TILE)
                    || (dst_i[dma_pkg::REGION_LSB +: dma_pkg::REGION_WIDTH] == dma_pkg::REGION_CONFIG);

    // Abort in the same cycle wins over start
    assign accept      = start_i && !abort_i && !busy_o && (size_i != '0) && region_ok;
    assign cmd_start_o = accept;

    // Byte size rounded up to whole words
    assign cmd_o.src   = src_i;
    assign cmd_o.dst   = dst_i;
    assign cmd_o.words = (dma_pkg::words_t'(size_i) + (dma_pkg::BYTES_PER_WORD - 1))
                         / dma_pkg::BYTES_PER_WORD;

    always_ff @(posedge clk) begin
        if (!rst_n || abort_i) begin
            busy_o  <= 1'b0;
            settled <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (accept) begin
                busy_o  <= 1'b1;
                settled <= 1'b0;
            end else if (busy_o && !settled) begin
                settled <= 1'b1;
            end else if (busy_o && rd_idle_i && wr_idle_i && fifo_empty_i) begin
                // Done pulses in the cycle busy falls
                busy_o  <= 1'b0;
                settled <= 1'b0;
                done_q  <= 1'b1;
            end
        end
    end

    assign done_o = done_q;
    assign irq_o  = done_q;

endmodule

/* logic/dma_word_fifo.sv */
`timescale 1ns/1ps

module dma_word_fifo (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush_i,
    input  logic                 abort_i,
    input  logic                 push_i,
    input  dma_pkg::data_t       push_data_i,
    input  logic                 pop_i,
    output dma_pkg::data_t       head_o,
    output dma_pkg::fifo_count_t free_o,
    output logic                 full_o,
    output logic                 empty_o
);

    dma_pkg::data_t       mem [dma_pkg::FIFO_DEPTH];
    dma_pkg::fifo_ptr_t   wr_ptr;
    dma_pkg::fifo_ptr_t   rd_ptr;
    dma_pkg::fifo_count_t count;

    // Pointers wrap naturally since depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n || flush_i || abort_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // Head word visible combinationally to the writer
    assign head_o  = mem[rd_ptr];
    assign free_o  = dma_pkg::fifo_count_t'(dma_pkg::FIFO_DEPTH) - count;
    assign full_o  = (count == dma_pkg::fifo_count_t'(dma_pkg::FIFO_DEPTH));
    assign empty_o = (count == '0);

endmodule

/* read_engine/dma_read_engine.sv */
`timescale 1ns/1ps

module dma_read_engine (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 abort_i,
    input  logic                 cmd_start_i,
    input  dma_pkg::dma_cmd_t    cmd_i,
    input  dma_pkg::fifo_count_t fifo_free_i,
    input  logic                 fifo_full_i,
    output dma_pkg::axi_ar_t     ar_o,
    output logic                 arvalid_o,
    input  logic                 arready_i,
    input  dma_pkg::data_t       rdata_i,
    input  logic                 rlast_i,
    input  logic                 rvalid_i,
    output logic                 rready_o,
    output logic                 push_o,
    output dma_pkg::data_t       push_data_o,
    output logic                 idle_o
);

    dma_pkg::read_state_t state;
    dma_pkg::addr_t       rd_addr;
    dma_pkg::words_t      words_left;
    // Beats of the burst in flight
    dma_pkg::fifo_count_t burst_q;

    dma_pkg::words_t      page_words;
    dma_pkg::words_t      next_words;
    dma_pkg::fifo_count_t burst_len;
    logic                 issue;

    // ==========================================================
    // Burst sizing
    // ==========================================================
    // Smallest of words left, FIFO depth and words to page end
    always_comb begin
        page_words = dma_pkg::words_t'((dma_pkg::PAGE_BYTES
                     - rd_addr[dma_pkg::PAGE_OFFSET_WIDTH-1:0]) / dma_pkg::BYTES_PER_WORD);
        next_words = dma_pkg::words_t'(dma_pkg::FIFO_DEPTH);
        if (words_left < next_words) begin
            next_words = words_left;
        end
        if (page_words < next_words) begin
            next_words = page_words;
        end
        burst_len = dma_pkg::fifo_count_t'(next_words);
    end

    // Wait until the whole burst fits in the FIFO
    assign issue = (state == dma_pkg::R_ADDR) && !arvalid_o && (fifo_free_i >= burst_len);

    // ==========================================================
    // Read FSM
    // ==========================================================
    always_ff @(posedge clk) begin
        if (!rst_n || abort_i) begin
            state      <= dma_pkg::R_IDLE;
            arvalid_o  <= 1'b0;
            rd_addr    <= '0;
            words_left <= '0;
        end else begin
            case (state)
                dma_pkg::R_IDLE: begin
                    if (cmd_start_i) begin
                        rd_addr    <= cmd_i.src;
                        words_left <= cmd_i.words;
                        state      <= dma_pkg::R_ADDR;
                    end
                end
                dma_pkg::R_ADDR: begin
                    // Valid held until the slave takes it
                    if (issue) begin
                        arvalid_o <= 1'b1;
                    end else if (arvalid_o && arready_i) begin
                        arvalid_o <= 1'b0;
                        state     <= dma_pkg::R_DATA;
                    end
                end
                dma_pkg::R_DATA: begin
                    if (push_o) begin
                        words_left <= words_left - 1'b1;
                        if (rlast_i) begin
                            rd_addr <= rd_addr
                                       + dma_pkg::addr_t'(burst_q) * dma_pkg::BYTES_PER_WORD;
                            if (words_left == dma_pkg::words_t'(1)) begin
                                state <= dma_pkg::R_DONE;
                            end else begin
                                state <= dma_pkg::R_ADDR;
                            end
                        end
                    end
                end
                dma_pkg::R_DONE: state <= dma_pkg::R_IDLE;
                default:         state <= dma_pkg::R_IDLE;
            endcase
        end
    end

    // AR payload captured together with the valid rise
    always_ff @(posedge clk) begin
        if (issue) begin
            ar_o.addr <= rd_addr;
            ar_o.len  <= dma_pkg::axi_len_t'(burst_len - 1'b1);
            burst_q   <= burst_len;
        end
    end

    // Beats stall while the FIFO is full
    assign rready_o    = (state == dma_pkg::R_DATA) && !fifo_full_i;
    assign push_o      = rvalid_i && rready_o;
    assign push_data_o = rdata_i;
    assign idle_o      = (state == dma_pkg::R_IDLE);

endmodule

/* sources.f */
common/dma_pkg.sv
logic/dma_word_fifo.sv
read_engine/dma_read_engine.sv
write_engine/dma_local_writer.sv
logic/dma_status_ctrl.sv
logic/cgra_dma_engine.sv
verification/axi_read_mem_model.sv
verification/tb_cgra_dma.sv

/* verification/axi_read_mem_model.sv */
`timescale 1ns/1ps

module axi_read_mem_model (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             abort_i,
    input  dma_pkg::axi_ar_t ar_i,
    input  logic             arvalid_i,
    output logic             arready_o,
    output dma_pkg::data_t   rdata_o,
    output logic             rlast_o,
    output logic             rvalid_o,
    input  logic             rready_i,
    output logic             burst_err_o
);

    integer            seed = 50412;
    logic              in_burst;
    dma_pkg::addr_t    base_q;
    dma_pkg::axi_len_t len_q;
    dma_pkg::axi_len_t beat_q;

    // Word at a byte address, a fixed mix of the address bits
    function automatic dma_pkg::data_t word_at(input dma_pkg::addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    assign rdata_o = word_at(base_q + dma_pkg::addr_t'(beat_q) * 4);
    assign rlast_o = in_burst && (beat_q == len_q);

    always @(posedge clk) begin
        if (!rst_n || abort_i) begin
            // Abort throws away the burst in flight
            in_burst  <= 1'b0;
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            beat_q    <= '0;
        end else if (!in_burst) begin
            if (arvalid_i && arready_o) begin
                base_q    <= ar_i.addr;
                len_q     <= ar_i.len;
                beat_q    <= '0;
                in_burst  <= 1'b1;
                arready_o <= 1'b0;
            end else begin
                // Random AR stalls
                arready_o <= ($random(seed) & 3) != 0;
            end
        end else if (rvalid_o && rready_i && rlast_o) begin
            in_burst <= 1'b0;
            rvalid_o <= 1'b0;
        end else begin
            if (rvalid_o && rready_i) begin
                beat_q <= beat_q + 1'b1;
            end
            // Valid only drops after a beat was taken
            if (!rvalid_o || rready_i) begin
                rvalid_o <= ($random(seed) & 3) != 0;
            end
        end
    end

    // Sticky flag: burst over FIFO depth or across a 4 KB page
    always @(posedge clk) begin
        if (!rst_n) begin
            burst_err_o <= 1'b0;
        end else if (arvalid_i && arready_o && !in_burst) begin
            if ((ar_i.len > 8'(dma_pkg::FIFO_DEPTH - 1))
                || (32'(ar_i.addr[11:0]) + 32'(ar_i.len) * 4 + 4 > dma_pkg::PAGE_BYTES)) begin
                burst_err_o <= 1'b1;
            end
        end
    end

endmodule

/* verification/tb_cgra_dma.sv */
`timescale 1ns/1ps

module tb_cgra_dma;

    typedef enum logic [1:0] {OUT_REJECT, OUT_DONE, OUT_ABORT} outcome_t;

    // Source, destination, byte size, abort cycle after start, outcome
    typedef struct packed {
        dma_pkg::addr_t src;
        dma_pkg::addr_t dst;
        dma_pkg::addr_t size;
        logic [15:0]    abort_at;
        outcome_t       outcome;
    } row_t;

    logic              clk = 1'b0;
    logic              rst_n;
    dma_pkg::addr_t    src;
    dma_pkg::addr_t    dst;
    dma_pkg::addr_t    size;
    logic              start;
    logic              abort;
    logic              busy;
    logic              done;
    logic              irq;
    dma_pkg::axi_ar_t  ar;
    logic              arvalid;
    logic              arready;
    dma_pkg::data_t    rdata;
    logic              rlast;
    logic              rvalid;
    logic              rready;
    dma_pkg::tile_wr_t tile_wr;
    dma_pkg::cfg_wr_t  cfg_wr;
    logic              burst_err;

    // Scoreboard of the transfer in progress
    row_t              rows[$];
    dma_pkg::addr_t    cur_src;
    dma_pkg::addr_t    cur_dst;
    int                exp_words;
    int                wr_count;
    int                done_count;
    int                irq_count;
    logic              writes_allowed;

    always #50 clk = ~clk;

    cgra_dma_engine u_dut (
        .clk(clk), .rst_n(rst_n),
        .src_i(src), .dst_i(dst), .size_i(size), .start_i(start), .abort_i(abort),
        .busy_o(busy), .done_o(done), .irq_o(irq),
        .ar_o(ar), .arvalid_o(arvalid), .arready_i(arready),
        .rdata_i(rdata), .rlast_i(rlast), .rvalid_i(rvalid), .rready_o(rready),
        .tile_wr_o(tile_wr), .cfg_wr_o(cfg_wr)
    );

    axi_read_mem_model u_mem (
        .clk(clk), .rst_n(rst_n), .abort_i(abort),
        .ar_i(ar), .arvalid_i(arvalid), .arready_o(arready),
        .rdata_o(rdata), .rlast_o(rlast), .rvalid_o(rvalid), .rready_i(rready),
        .burst_err_o(burst_err)
    );

    // ============================================================
    // Reference rule and failure reporting
    // ============================================================
    function automatic dma_pkg::data_t expected_word(input dma_pkg::addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    task automatic halt_failed();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        halt_failed();
    endtask

    task automatic fail_with(input string what);
        $display("error at %0t ns: %s", $time, what);
        halt_failed();
    endtask

    task automatic add_row(input dma_pkg::addr_t s, input dma_pkg::addr_t d,
                           input dma_pkg::addr_t sz, input int at, input outcome_t o);
        row_t r;
        r.src      = s;
        r.dst      = d;
        r.size     = sz;
        r.abort_at = 16'(at);
        r.outcome  = o;
        rows.push_back(r);
    endtask

    // Word k goes from src + 4k to dst + 4k
    task automatic check_write();
        dma_pkg::addr_t exp_dst;
        dma_pkg::data_t exp_data;
        exp_dst  = cur_dst + dma_pkg::addr_t'(wr_count) * 4;
        exp_data = expected_word(cur_src + dma_pkg::addr_t'(wr_count) * 4);
        assert (writes_allowed) else fail_with("local write with no transfer running");
        assert (wr_count < exp_words) else fail_with("more local writes than words");
        if (cur_dst[31:28] == 4'h1) begin
            assert (!cfg_wr.we) else fail_with("config write during a tile transfer");
            assert (tile_wr.bank == exp_dst[13:12])
                else show_mismatch("tile_wr_o.bank", tile_wr.bank, exp_dst[13:12]);
            assert (tile_wr.offset == exp_dst[11:0])
                else show_mismatch("tile_wr_o.offset", tile_wr.offset, exp_dst[11:0]);
            assert (tile_wr.data == exp_data)
                else show_mismatch("tile_wr_o.data", tile_wr.data, exp_data);
        end else begin
            assert (!tile_wr.we) else fail_with("tile write during a config transfer");
            assert (cfg_wr.addr == exp_dst)
                else show_mismatch("cfg_wr_o.addr", cfg_wr.addr, exp_dst);
            assert (cfg_wr.data == exp_data)
                else show_mismatch("cfg_wr_o.data", cfg_wr.data, exp_data);
        end
        wr_count++;
    endtask

    // Sampled at the edge, before any register updates
    always @(posedge clk) begin
        if (rst_n) begin
            assert (!burst_err) else fail_with("AXI burst over 8 beats or across a 4 KB page");
            assert (done === irq) else show_mismatch("irq_o", irq, done);
            if (done) done_count++;
            if (irq) irq_count++;
            if (tile_wr.we || cfg_wr.we) check_write();
            // Writes seen at the abort edge still count
            if (abort) writes_allowed = 1'b0;
        end
    end

    // ============================================================
    // Apply one table row
    // ============================================================
    task automatic apply_row(input row_t r);
        int n;
        cur_src        = r.src;
        cur_dst        = r.dst;
        exp_words      = int'((r.size + 3) / 4);
        wr_count       = 0;
        done_count     = 0;
        irq_count      = 0;
        writes_allowed = (r.outcome != OUT_REJECT);
        src   <= r.src;
        dst   <= r.dst;
        size  <= r.size;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        if (r.outcome == OUT_REJECT) begin
            // Watch window with nothing allowed to happen
            for (n = 0; n < 40; n++) begin
                assert (busy === 1'b0) else show_mismatch("busy_o", busy, 0);
                @(posedge clk);
            end
            assert (done_count == 0 && wr_count == 0)
                else fail_with("rejected start gave a write or a done pulse");
        end else begin
            assert (busy === 1'b1) else show_mismatch("busy_o", busy, 1);
        end
        if (r.outcome == OUT_DONE) begin
            for (n = 0; n < 3000 && done !== 1'b1; n++) begin
                @(posedge clk);
            end
            assert (n < 3000) else fail_with("timeout waiting for done");
            // Busy falls in the done cycle
            assert (busy === 1'b0) else show_mismatch("busy_o", busy, 0);
            repeat (4) @(posedge clk);
            assert (wr_count == exp_words) else show_mismatch("write count", wr_count, exp_words);
            assert (done_count == 1 && irq_count == 1)
                else fail_with("done or irq did not pulse exactly once");
        end
        if (r.outcome == OUT_ABORT) begin
            for (n = 0; n < int'(r.abort_at); n++) begin
                @(posedge clk);
            end
            assert (busy === 1'b1 && wr_count < exp_words)
                else fail_with("transfer ended before the abort");
            abort <= 1'b1;
            @(posedge clk);
            abort <= 1'b0;
            @(posedge clk);
            assert (busy === 1'b0) else show_mismatch("busy_o", busy, 0);
            repeat (40) @(posedge clk);
            assert (done_count == 0 && irq_count == 0 && busy === 1'b0)
                else fail_with("done, irq or busy seen after abort");
        end
    endtask

    initial begin
        int i;
        rst_n          = 1'b0;
        src            = '0;
        dst            = '0;
        size           = '0;
        start          = 1'b0;
        abort          = 1'b0;
        writes_allowed = 1'b0;
        exp_words      = 0;
        wr_count       = 0;
        done_count     = 0;
        irq_count      = 0;

        // Tile bank 0, bank 2, odd size, config, page edge burst
        add_row(32'h0000_1000, 32'h1000_0000, 32'd16,  0,  OUT_DONE);
        add_row(32'h0000_2100, 32'h1000_2040, 32'd40,  0,  OUT_DONE);
        add_row(32'h0000_3000, 32'h1000_0100, 32'd13,  0,  OUT_DONE);
        add_row(32'h0000_4000, 32'h2000_0080, 32'd22,  0,  OUT_DONE);
        add_row(32'h0000_5ff4, 32'h1000_1000, 32'd160, 0,  OUT_DONE);
        // Zero size, region 0, region 3
        add_row(32'h0000_1000, 32'h1000_0000, 32'd0,   0,  OUT_REJECT);
        add_row(32'h0000_1000, 32'h0000_0000, 32'd16,  0,  OUT_REJECT);
        add_row(32'h0000_1000, 32'h3000_0000, 32'd16,  0,  OUT_REJECT);
        // Abort mid transfer, then a clean one
        add_row(32'h0000_6000, 32'h1000_3000, 32'd128, 20, OUT_ABORT);
        add_row(32'h0000_7000, 32'h1000_3100, 32'd32,  0,  OUT_DONE);

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (!busy && !done && !irq && !arvalid && !rready && !tile_wr.we && !cfg_wr.we)
            else fail_with("an output was not low after reset");

        for (i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* write_engine/dma_local_writer.sv */
`timescale 1ns/1ps

module dma_local_writer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                abort_i,
    input  logic                cmd_start_i,
    input  dma_pkg::dma_cmd_t   cmd_i,
    input  logic                fifo_empty_i,
    input  dma_pkg::data_t      fifo_head_i,
    output logic                pop_o,
    output dma_pkg::tile_wr_t   tile_wr_o,
    output dma_pkg::cfg_wr_t    cfg_wr_o,
    output logic                idle_o
);

    dma_pkg::write_state_t state;
    dma_pkg::addr_t        wr_addr;
    dma_pkg::words_t       words_left;
    dma_pkg::dst_region_t  region;
    // Word popped in W_WAIT, written in W_WRITE
    dma_pkg::data_t        data_q;

    // Pop as soon as a word is there
    assign pop_o = (state == dma_pkg::W_WAIT) && !fifo_empty_i;

    // ==========================================================
    // Writer FSM
    // ==========================================================
    always_ff @(posedge clk) begin
        if (!rst_n || abort_i) begin
            state      <= dma_pkg::W_IDLE;
            wr_addr    <= '0;
            words_left <= '0;
            region     <= dma_pkg::REGION_TILE;
        end else begin
            case (state)
                dma_pkg::W_IDLE: begin
                    if (cmd_start_i) begin
                        wr_addr    <= cmd_i.dst;
                        words_left <= cmd_i.words;
                        // Region already checked by the status controller
                        region     <= dma_pkg::dst_region_t'(
                                      cmd_i.dst[dma_pkg::REGION_LSB +: dma_pkg::REGION_WIDTH]);
                        state      <= dma_pkg::W_WAIT;
                    end
                end
                dma_pkg::W_WAIT: begin
                    if (pop_o) begin
                        state <= dma_pkg::W_WRITE;
                    end
                end
                dma_pkg::W_WRITE: begin
                    // Write enable is high for this one cycle
                    wr_addr    <= wr_addr + dma_pkg::BYTES_PER_WORD;
                    words_left <= words_left - 1'b1;
                    if (words_left == dma_pkg::words_t'(1)) begin
                        state <= dma_pkg::W_IDLE;
                    end else begin
                        state <= dma_pkg::W_WAIT;
                    end
                end
                default: state <= dma_pkg::W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            data_q <= fifo_head_i;
        end
    end

    // ==========================================================
    // Local write ports
    // ==========================================================
    always_comb begin
        // Tile space is 4 banks, bank from the bits above the offset
        tile_wr_o.we     = (state == dma_pkg::W_WRITE) && (region == dma_pkg::REGION_TILE);
        tile_wr_o.bank   = wr_addr[dma_pkg::TILE_OFFSET_WIDTH +: dma_pkg::TILE_BANK_WIDTH];
        tile_wr_o.offset = wr_addr[dma_pkg::TILE_OFFSET_WIDTH-1:0];
        tile_wr_o.data   = data_q;

        // Config port sees the full byte address
        cfg_wr_o.we      = (state == dma_pkg::W_WRITE) && (region == dma_pkg::REGION_CONFIG);
        cfg_wr_o.addr    = wr_addr;
        cfg_wr_o.data    = data_q;
    end

    assign idle_o = (state == dma_pkg::W_IDLE);

endmodule
